// ==== dcache_axi_bridge.f ====
verilog/dcache_axi_pkg.sv
verilog/line_refill.sv
verilog/line_writeback.sv
verilog/dcache_axi_bridge.sv
testbench/tb_dcache_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the bridge testbench with Verilator, runs it, judges the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dcache_axi_bridge \
    -f dcache_axi_bridge.f -o tb_dcache_axi_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache_axi_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== testbench/dcache_stimulus.txt ====
# test, op (R, W or RW), line address, eight words
# R: slave read data  W: line written back  RW: both, write line at address + 1000
rd_basic    R  00001000 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
rd_pattern  R  8000ffe0 a5a5a5a5 5a5a5a5a 00000000 ffffffff 0f0f0f0f f0f0f0f0 12345678 87654321
rd_high     R  fffffe00 deadbeef cafef00d 0badc0de 8badf00d 00c0ffee 1badb002 feedface 0d15ea5e
wr_basic    W  00002000 01020304 05060708 090a0b0c 0d0e0f10 11121314 15161718 191a1b1c 1d1e1f20
wr_pattern  W  40000040 ffffffff 00000000 aaaaaaaa 55555555 cccccccc 33333333 f00ff00f 0ff00ff0
wr_walk     W  7ffff000 00000001 00000002 00000004 00000008 00000010 00000020 00000040 00000080
rw_both     RW 00003000 13579bdf 2468ace0 fdb97531 0eca8642 c001d00d b16b00b5 facefeed 600dcafe
rw_again    RW 10000020 99999999 88888888 77777777 66666666 55555555 44444444 33333333 22222222

// ==== testbench/tb_dcache_axi_bridge.sv ====
module tb_dcache_axi_bridge;
    import dcache_axi_pkg::*;

    localparam int LINE_WORDS = 8;
    localparam int MAX_TESTS  = 32;

    logic                   clk;
    logic                   rst_n;
    logic                   rd_req;
    addr_t                  rd_addr;
    logic                   rd_rdy;
    logic                   ret_valid;
    word_t [LINE_WORDS-1:0] ret_line;
    logic                   wr_req;
    addr_t                  wr_addr;
    word_t [LINE_WORDS-1:0] wr_line;
    logic                   wr_rdy;
    axi_ar_t                ar;
    axi_r_t                 r;
    axi_aw_t                aw;
    axi_w_t                 w;
    logic                   arvalid, arready, rvalid, rready;
    logic                   awvalid, awready, wvalid, wready;
    logic [1:0]             bresp;
    logic                   bvalid, bready;

    // stimulus table
    string names [MAX_TESTS];
    logic  rd_op [MAX_TESTS];
    logic  wr_op [MAX_TESTS];
    addr_t addrs [MAX_TESTS];
    word_t data  [MAX_TESTS][LINE_WORDS];

    integer seed;
    int     n_tests, n_run, fail_tests, test_errs, cur, cycles, limit;
    int     r_idx, w_idx, b_delay, post_b;
    string  cur_name;
    addr_t  wb_addr;
    logic   rd_on, rd_acc, ar_done, ret_seen, rd_fin, r_hs;
    logic   wr_on, wr_acc, aw_done, b_seen, wr_fin;

    dcache_axi_bridge #(
        .LINE_WORDS(LINE_WORDS)
    ) dcache_axi_bridge_i (
        .clk(clk), .rst_n(rst_n),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_line(ret_line),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_line(wr_line), .wr_rdy(wr_rdy),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic random_bit();
        return ($random(seed) & 3) != 0;   // high about 3 cycles in 4
    endfunction

    // 8-beat INCR burst of 4-byte words
    function automatic axi_ar_t line_burst(input addr_t a);
        return '{addr: a, len: 4'(LINE_WORDS - 1), size: 3'b010, burst: 2'b01};
    endfunction

    function automatic axi_w_t beat_of(input int k);
        return '{data: data[cur][k], strb: 4'b1111, last: (k == LINE_WORDS - 1)};
    endfunction

    task automatic flag_fault(input string msg);
        $display("%s: %s", cur_name, msg);
        test_errs++;
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ar(input string what, input axi_ar_t exp, input axi_ar_t act);
        check_addr({what, ".addr"}, exp.addr, act.addr);
        if ({act.len, act.size, act.burst} !== {exp.len, exp.size, exp.burst}) begin
            $display("[ERROR] %s %s: expected len/size/burst %h/%h/%h, actual %h/%h/%h",
                     cur_name, what, exp.len, exp.size, exp.burst,
                     act.len, act.size, act.burst);
            test_errs++;
        end
    endtask

    task automatic check_w(input string what, input axi_w_t exp, input axi_w_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected data/strb/last %h/%h/%b, actual %h/%h/%b",
                     cur_name, what, exp.data, exp.strb, exp.last,
                     act.data, act.strb, act.last);
            test_errs++;
        end
    endtask

    task automatic load_tests;
        int               fd;
        int               cnt;
        logic [8*256-1:0] text;
        logic [8*32-1:0]  name_raw;
        logic [8*4-1:0]   op_raw;
        addr_t            a;
        word_t            v [LINE_WORDS];
        n_tests = 0;
        fd = $fopen("testbench/dcache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/dcache_stimulus.txt");
            return;
        end
        while ($fgets(text, fd) != 0 && n_tests < MAX_TESTS) begin
            cnt = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h", name_raw, op_raw, a,
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            if (cnt == 11) begin   // comment lines stop short
                names[n_tests] = string'(name_raw);
                rd_op[n_tests] = string'(op_raw) != "W";
                wr_op[n_tests] = string'(op_raw) != "R";
                addrs[n_tests] = a;
                data[n_tests]  = v;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // sample at negedge, drive 1 after posedge
    task automatic cycle_step;
        @(negedge clk);
        r_hs = rvalid && rready;
        if (ret_valid && !(rd_on && rd_acc && !ret_seen))
            flag_fault("ret_valid outside an active refill");
        if (rd_on && !rd_acc) begin
            rd_acc = rd_req && rd_rdy;
        end else if (rd_on && !ret_seen) begin
            if (rd_rdy)
                flag_fault("rd_rdy high during refill");
            if (arvalid && arready) begin
                if (ar_done)
                    flag_fault("more than one AR transfer");
                check_ar("ar", line_burst(addrs[cur]), ar);
                ar_done = 1'b1;
            end
            if (r_hs)
                r_idx++;
            if (ret_valid) begin
                ret_seen = 1'b1;
                if (r_idx != LINE_WORDS)
                    flag_fault("ret_valid before the last R beat");
                for (int k = 0; k < LINE_WORDS; k++)
                    check_word($sformatf("ret_line[%0d]", k), data[cur][k], ret_line[k]);
            end
        end else if (rd_on && !rd_fin) begin
            if (!rd_rdy)
                flag_fault("rd_rdy not high the cycle after ret_valid");
            rd_fin = 1'b1;
        end
        if (wr_on && !wr_acc) begin
            wr_acc = wr_req && wr_rdy;
        end else if (wr_on && !b_seen) begin
            if (wr_rdy)
                flag_fault("wr_rdy high during writeback");
            if (awvalid && awready) begin
                if (aw_done)
                    flag_fault("more than one AW transfer");
                check_ar("aw", line_burst(wb_addr), axi_ar_t'(aw));
                aw_done = 1'b1;
            end
            if (wvalid && wready) begin
                if (w_idx < LINE_WORDS)
                    check_w($sformatf("w beat %0d", w_idx), beat_of(w_idx), w);
                else
                    flag_fault("W beat beyond the end of the burst");
                w_idx++;
            end
            if (bready && w_idx != LINE_WORDS)
                flag_fault("bready high before the last W beat");
            if (bvalid && bready) begin
                b_seen = 1'b1;
                if (!aw_done)
                    flag_fault("B transfer without an AW transfer");
            end
        end else if (wr_on && !wr_fin) begin
            post_b++;
            if (wr_rdy) begin
                wr_fin = 1'b1;
            end else if (post_b == 2) begin
                flag_fault("wr_rdy not high within two cycles of the B transfer");
                wr_fin = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        if (rd_acc)
            rd_req = 1'b0;
        if (wr_acc)
            wr_req = 1'b0;
        arready = random_bit();
        awready = random_bit();
        wready  = random_bit();
        if (!rvalid || r_hs) begin   // a raised rvalid waits for rready
            rvalid = ar_done && r_idx < LINE_WORDS && random_bit();
            r = '{data: data[cur][r_idx % LINE_WORDS], resp: 2'b00,
                  last: (r_idx == LINE_WORDS - 1)};
        end
        if (b_seen) begin
            bvalid = 1'b0;
        end else if (w_idx == LINE_WORDS && !bvalid) begin
            if (b_delay == 0)
                bvalid = 1'b1;
            else
                b_delay--;
        end
    endtask

    task automatic report_test;
        n_run++;
        if (test_errs == 0) begin
            $display("test %s: passed", cur_name);
        end else begin
            $display("test %s: failed, %0d errors", cur_name, test_errs);
            fail_tests++;
        end
    endtask

    task automatic run_test(input int idx);
        cur       = idx;
        cur_name  = names[idx];
        test_errs = 0;
        rd_on     = rd_op[idx];
        wr_on     = wr_op[idx];
        {rd_acc, ar_done, ret_seen, rd_fin} = '0;
        {wr_acc, aw_done, b_seen, wr_fin}   = '0;
        r_idx   = 0;
        w_idx   = 0;
        post_b  = 0;
        b_delay = $unsigned($random(seed)) % 4;
        wb_addr = (rd_on && wr_on) ? addrs[idx] + 32'h1000 : addrs[idx];
        rd_req  = rd_on;   // both requests in the same cycle for RW
        rd_addr = addrs[idx];
        wr_req  = wr_on;
        wr_addr = wb_addr;
        for (int k = 0; k < LINE_WORDS; k++)
            wr_line[k] = data[idx][k];
        while ((rd_on && !rd_fin) || (wr_on && !wr_fin))
            cycle_step();
        report_test();
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        rd_req  = 1'b0;
        rd_addr = '0;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_line = '0;
        arready = 1'b0;
        r       = '0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bresp   = 2'b00;
        bvalid  = 1'b0;
        seed    = 32'h4e5b_a8b4;
        {rd_on, wr_on, ar_done, b_seen} = '0;
        {n_run, fail_tests, cycles, limit, r_idx, w_idx, cur} = '0;
        load_tests();
        limit = (n_tests + 1) * (LINE_WORDS * 8 + 40);   // reset check is one more
        repeat (4) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        cur_name  = "reset";
        test_errs = 0;
        @(negedge clk);
        if (!rd_rdy || !wr_rdy)
            flag_fault("rd_rdy or wr_rdy low after reset");
        if (arvalid || rready || awvalid || wvalid || bready || ret_valid)
            flag_fault("a valid or ready output is high after reset");
        @(posedge clk);
        #1;
        report_test();
        if (n_tests == 0) begin
            $display("no tests read from the stimulus file");
            fail_tests++;
        end
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        $display("%0d tests, %0d passed, %0d failed", n_run, n_run - fail_tests, fail_tests);
        if (fail_tests == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog/dcache_axi_bridge.sv ====
module dcache_axi_bridge #(
    parameter int LINE_WORDS = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rd_req,
    input  dcache_axi_pkg::addr_t                  rd_addr,
    output logic                                   rd_rdy,
    output logic                                   ret_valid,
    output dcache_axi_pkg::word_t [LINE_WORDS-1:0] ret_line,
    input  logic                                   wr_req,
    input  dcache_axi_pkg::addr_t                  wr_addr,
    input  dcache_axi_pkg::word_t [LINE_WORDS-1:0] wr_line,
    output logic                                   wr_rdy,
    output dcache_axi_pkg::axi_ar_t                ar,
    output logic                                   arvalid,
    input  logic                                   arready,
    input  dcache_axi_pkg::axi_r_t                 r,
    input  logic                                   rvalid,
    output logic                                   rready,
    output dcache_axi_pkg::axi_aw_t                aw,
    output logic                                   awvalid,
    input  logic                                   awready,
    output dcache_axi_pkg::axi_w_t                 w,
    output logic                                   wvalid,
    input  logic                                   wready,
    input  logic [1:0]                             bresp,
    input  logic                                   bvalid,
    output logic                                   bready
);
    import dcache_axi_pkg::*;

    // read channels only
    line_refill #(
        .LINE_WORDS(LINE_WORDS)
    ) line_refill_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_rdy   (rd_rdy),
        .ret_valid(ret_valid),
        .ret_line (ret_line),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    // write channels only, so no arbitration between the two
    line_writeback #(
        .LINE_WORDS(LINE_WORDS)
    ) line_writeback_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_req (wr_req),
        .wr_addr(wr_addr),
        .wr_line(wr_line),
        .wr_rdy (wr_rdy),
        .aw     (aw),
        .awvalid(awvalid),
        .awready(awready),
        .w      (w),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready)
    );

endmodule

// ==== verilog/line_writeback.sv ====
module line_writeback #(
    parameter int LINE_WORDS = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr_req,
    input  dcache_axi_pkg::addr_t                  wr_addr,
    input  dcache_axi_pkg::word_t [LINE_WORDS-1:0] wr_line,
    output logic                                   wr_rdy,
    output dcache_axi_pkg::axi_aw_t                aw,
    output logic                                   awvalid,
    input  logic                                   awready,
    output dcache_axi_pkg::axi_w_t                 w,
    output logic                                   wvalid,
    input  logic                                   wready,
    input  logic [1:0]                             bresp,   // not checked
    input  logic                                   bvalid,
    output logic                                   bready
);
    import dcache_axi_pkg::*;

    localparam int CNT_W = $clog2(LINE_WORDS);

    wb_state_t              state;
    wb_state_t              state_next;
    addr_t                  victim_addr;
    word_t [LINE_WORDS-1:0] victim_line;
    logic [CNT_W-1:0]       beat_cnt;
    logic                   last_beat;
    logic                   w_fire;

    assign last_beat = (beat_cnt == CNT_W'(LINE_WORDS - 1));
    assign w_fire    = wvalid && wready;

    always_comb begin
        state_next = state;
        unique case (state)
            WB_IDLE: begin
                if (wr_req) begin
                    state_next = WB_ADDR;
                end
            end
            WB_ADDR: begin
                if (awready) begin
                    state_next = WB_DATA;
                end
            end
            WB_DATA: begin
                if (w_fire && last_beat) begin
                    state_next = WB_RESP;
                end
            end
            WB_RESP: begin
                if (bvalid) begin
                    state_next = WB_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // victim held for the whole burst
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && wr_req) begin
            victim_addr <= wr_addr;
            victim_line <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (state == WB_ADDR) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;   // stalled beat keeps its word
        end
    end

    assign aw = '{
        addr:  victim_addr,
        len:   axi_len_t'(LINE_WORDS - 1),
        size:  AXI_SIZE_WORD,
        burst: AXI_BURST_INCR
    };

    assign w = '{
        data: victim_line[beat_cnt],
        strb: STRB_ALL,
        last: last_beat
    };

    assign awvalid = (state == WB_ADDR);
    assign wvalid  = (state == WB_DATA);
    assign bready  = (state == WB_RESP);
    assign wr_rdy  = (state == WB_IDLE);

endmodule

// ==== verilog/line_refill.sv ====
module line_refill #(
    parameter int LINE_WORDS = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rd_req,
    input  dcache_axi_pkg::addr_t                  rd_addr,
    output logic                                   rd_rdy,
    output logic                                   ret_valid,
    output dcache_axi_pkg::word_t [LINE_WORDS-1:0] ret_line,
    output dcache_axi_pkg::axi_ar_t                ar,
    output logic                                   arvalid,
    input  logic                                   arready,
    input  dcache_axi_pkg::axi_r_t                 r,
    input  logic                                   rvalid,
    output logic                                   rready
);
    import dcache_axi_pkg::*;

    localparam int CNT_W = $clog2(LINE_WORDS);

    refill_state_t          state;
    refill_state_t          state_next;
    addr_t                  miss_addr;
    word_t [LINE_WORDS-1:0] line_buf;
    logic [CNT_W-1:0]       beat_cnt;
    logic                   r_fire;

    assign r_fire = rvalid && rready;

    always_comb begin
        state_next = state;
        unique case (state)
            RF_IDLE: begin
                if (rd_req) begin
                    state_next = RF_ADDR;
                end
            end
            RF_ADDR: begin
                if (arready) begin
                    state_next = RF_DATA;
                end
            end
            RF_DATA: begin
                if (r_fire && r.last) begin   // burst ends on last, not on count
                    state_next = RF_DONE;
                end
            end
            RF_DONE: begin
                state_next = RF_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RF_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && rd_req) begin
            miss_addr <= rd_addr;
        end
    end

    // beat index into the line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (state == RF_ADDR) begin
            beat_cnt <= '0;
        end else if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            line_buf[beat_cnt] <= r.data;
        end
    end

    assign ar = '{
        addr:  miss_addr,
        len:   axi_len_t'(LINE_WORDS - 1),
        size:  AXI_SIZE_WORD,
        burst: AXI_BURST_INCR
    };

    assign arvalid   = (state == RF_ADDR);
    assign rready    = (state == RF_DATA);
    assign ret_valid = (state == RF_DONE);   // one cycle pulse
    assign ret_line  = line_buf;
    assign rd_rdy    = (state == RF_IDLE);

endmodule

// ==== verilog/dcache_axi_pkg.sv ====
package dcache_axi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  axi_len_t;   // beats minus one

    // read address channel payload
    typedef struct packed {
        addr_t      addr;
        axi_len_t   len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    // write address, same layout as ar
    typedef struct packed {
        addr_t      addr;
        axi_len_t   len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;   // 4 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] STRB_ALL       = 4'b1111;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA,
        RF_DONE
    } refill_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

endpackage
